// ==== include/i2c_master_params.svh ====
`ifndef I2C_MASTER_PARAMS_SVH
`define I2C_MASTER_PARAMS_SVH

// byte framing on the bus
`define I2C_BYTE_BITS   8       // scl rises per byte without the ack slot

// bit index handed to the shift datapath
`define I2C_BIT_IDX_W   4
`define I2C_BIT_MSB     7       // msb is shifted first

`endif

// ==== rtl/i2c_fsm_pkg.sv ====
`default_nettype none

package i2c_fsm_pkg;

    // -------------------------------------------------------------------
    // controller states
    // -------------------------------------------------------------------
    typedef enum logic [3:0] {
        IDLE           = 4'b0000,
        START          = 4'b0001,
        ADDRESS        = 4'b0010,   // address byte out
        READ_ACK       = 4'b0011,   // slave acks the address
        WRITE_DATA     = 4'b0100,
        READ_LATER_ACK = 4'b0101,   // slave acks a data byte
        READ_DATA      = 4'b0110,
        WRITE_ACK      = 4'b0111,   // master acks a data byte
        REPEAT_START   = 4'b1000,
        STOP           = 4'b1001
    } i2c_state_e;

endpackage

`default_nettype wire

// ==== rtl/i2c_bus_pkg.sv ====
`default_nettype none

`include "i2c_master_params.svh"

package i2c_bus_pkg;

    // direction carried by the r/w bit of the address byte
    typedef enum logic {
        I2C_WRITE = 1'b0,
        I2C_READ  = 1'b1
    } i2c_dir_e;

    // index of the bit the datapath shifts next
    typedef logic [`I2C_BIT_IDX_W-1:0] bit_idx_t;

endpackage

`default_nettype wire

// ==== rtl/i2c_bit_timer.sv ====
`default_nettype none

`include "i2c_master_params.svh"

module i2c_bit_timer
    import i2c_fsm_pkg::*;
    import i2c_bus_pkg::*;
(
    input  wire logic       i2c_core_clk_i,
    input  wire logic       reset_ni,
    input  wire logic       i2c_scl_i,      // scl as seen on the bus
    input  wire i2c_state_e state_i,
    output logic            scl_rise_o,
    output logic            scl_fall_o,
    output logic            byte_done_o,    // falling edge after the last rise of a byte
    output bit_idx_t        count_bit_o
);

    localparam logic [`I2C_BIT_IDX_W-1:0] BYTE_RISES = `I2C_BYTE_BITS;
    localparam bit_idx_t                  FIRST_BIT  = `I2C_BIT_MSB;

    logic                       scl_q;
    logic                       byte_phase;
    logic                       index_on_rise;
    logic                       idx_step;
    logic [`I2C_BIT_IDX_W-1:0]  rise_cnt_q;
    bit_idx_t                   bit_idx_q;

    // -------------------------------------------------------------------
    // scl edge detect
    // -------------------------------------------------------------------
    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            scl_q <= 1'b1;  // bus idles high
        end else begin
            scl_q <= i2c_scl_i;
        end
    end

    assign scl_rise_o = i2c_scl_i & ~scl_q;
    assign scl_fall_o = ~i2c_scl_i & scl_q;

    assign byte_phase    = (state_i == ADDRESS) || (state_i == WRITE_DATA)
                         || (state_i == READ_DATA);
    assign index_on_rise = (state_i == ADDRESS) || (state_i == WRITE_DATA);

    // -------------------------------------------------------------------
    // rise counter and bit index
    // -------------------------------------------------------------------
    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            rise_cnt_q <= '0;
        end else if (!byte_phase) begin
            rise_cnt_q <= '0;
        end else if (scl_rise_o) begin
            rise_cnt_q <= rise_cnt_q + 1'b1;
        end
    end

    assign byte_done_o = byte_phase & scl_fall_o & (rise_cnt_q == BYTE_RISES);

    // transmit shifts on rises while receive samples up to the fall
    assign idx_step = index_on_rise ? scl_rise_o : scl_fall_o;

    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            bit_idx_q <= FIRST_BIT;
        end else if (!byte_phase) begin
            bit_idx_q <= FIRST_BIT;
        end else if (idx_step && (bit_idx_q != '0)) begin
            bit_idx_q <= bit_idx_q - 1'b1;  // holds at 0
        end
    end

    assign count_bit_o = bit_idx_q;

endmodule

`default_nettype wire

// ==== rtl/i2c_ack_monitor.sv ====
`default_nettype none

module i2c_ack_monitor
    import i2c_fsm_pkg::*;
    import i2c_bus_pkg::*;
(
    input  wire logic       i2c_core_clk_i,
    input  wire logic       reset_ni,
    input  wire i2c_state_e state_i,
    input  wire logic       scl_rise_i,
    input  wire logic       i2c_sda_i,
    input  wire logic       full_i,         // rx fifo full
    input  wire logic       empty_i,        // tx fifo empty
    input  wire i2c_dir_e   rw_i,
    output logic            read_go_o,
    output logic            write_go_o
);

    logic ack_slot;
    logic acked;

    assign ack_slot = (state_i == READ_ACK) || (state_i == READ_LATER_ACK);

    // slave holds sda low through the high phase of the ack clock
    assign acked = scl_rise_i & ~i2c_sda_i;

    // -------------------------------------------------------------------
    // go flags held until the ack slot is left
    // -------------------------------------------------------------------
    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            read_go_o  <= 1'b0;
            write_go_o <= 1'b0;
        end else if (!ack_slot) begin
            read_go_o  <= 1'b0;
            write_go_o <= 1'b0;
        end else if (acked && (rw_i == I2C_READ) && !full_i) begin
            read_go_o  <= 1'b1;  // room left in rx fifo
            write_go_o <= 1'b0;
        end else if (acked && (rw_i == I2C_WRITE) && !empty_i) begin
            read_go_o  <= 1'b0;
            write_go_o <= 1'b1;  // tx fifo has a byte
        end
    end

endmodule

`default_nettype wire

// ==== rtl/i2c_sequencer.sv ====
`default_nettype none

module i2c_sequencer
    import i2c_fsm_pkg::*;
(
    input  wire logic   i2c_core_clk_i,
    input  wire logic   reset_ni,
    input  wire logic   enable_i,
    input  wire logic   repeat_start_i,
    input  wire logic   full_i,
    input  wire logic   empty_i,
    input  wire logic   i2c_sda_i,
    input  wire logic   i2c_scl_i,
    input  wire logic   scl_rise_i,
    input  wire logic   scl_fall_i,
    input  wire logic   byte_done_i,
    input  wire logic   read_go_i,
    input  wire logic   write_go_i,
    output i2c_state_e  state_o,
    output logic        w_fifo_en_o,        // push received byte to rx fifo
    output logic        r_fifo_en_o,        // pop next byte from tx fifo
    output logic        sda_low_en_o,
    output logic        clk_en_o,
    output logic        write_data_en_o,
    output logic        write_addr_en_o,
    output logic        receive_data_en_o,
    output logic        i2c_sda_en_o,
    output logic        i2c_scl_en_o,
    output logic        start_done_o
);

    i2c_state_e state_q;
    i2c_state_e state_d;

    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign state_o = state_q;

    // -------------------------------------------------------------------
    // next state
    // -------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (enable_i) state_d = START;
            end
            START: begin
                if (!i2c_scl_i) state_d = ADDRESS;  // start condition done once scl low
            end
            ADDRESS: begin
                if (byte_done_i) state_d = READ_ACK;
            end
            READ_ACK: begin
                if (scl_fall_i) begin
                    if (read_go_i) begin
                        state_d = READ_DATA;
                    end else if (write_go_i) begin
                        state_d = WRITE_DATA;
                    end else begin
                        state_d = STOP;     // nack or fifo not ready
                    end
                end
            end
            WRITE_DATA: begin
                if (byte_done_i) state_d = READ_LATER_ACK;
            end
            READ_LATER_ACK: begin
                if (scl_fall_i) begin
                    if (empty_i || (!write_go_i && !repeat_start_i)) begin
                        state_d = STOP;
                    end else if (!write_go_i) begin
                        state_d = REPEAT_START;
                    end else begin
                        state_d = WRITE_DATA;
                    end
                end
            end
            READ_DATA: begin
                if (byte_done_i) state_d = WRITE_ACK;
            end
            WRITE_ACK: begin
                if (scl_fall_i) begin
                    if (repeat_start_i) begin
                        state_d = REPEAT_START;
                    end else if (!full_i) begin
                        state_d = READ_DATA;
                    end else begin
                        state_d = STOP;
                    end
                end
            end
            REPEAT_START: begin
                if (scl_rise_i) state_d = START;
            end
            STOP: begin
                if (scl_rise_i) state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    // -------------------------------------------------------------------
    // line and datapath enables
    // -------------------------------------------------------------------
    always_comb begin
        clk_en_o          = 1'b1;
        sda_low_en_o      = 1'b0;
        write_data_en_o   = 1'b0;
        write_addr_en_o   = 1'b0;
        receive_data_en_o = 1'b0;
        i2c_sda_en_o      = 1'b0;
        i2c_scl_en_o      = 1'b1;
        start_done_o      = 1'b1;
        case (state_q)
            IDLE: begin
                clk_en_o     = 1'b0;
                i2c_scl_en_o = 1'b0;
                start_done_o = 1'b0;
            end
            START: begin
                sda_low_en_o = 1'b1;
                i2c_sda_en_o = 1'b1;
            end
            ADDRESS: begin
                write_addr_en_o = ~i2c_scl_i;   // sda changes only while scl low
                i2c_sda_en_o    = 1'b1;
            end
            WRITE_DATA: begin
                write_data_en_o = ~i2c_scl_i;
                i2c_sda_en_o    = 1'b1;
            end
            READ_LATER_ACK: begin
                sda_low_en_o = 1'b1;
            end
            READ_DATA: begin
                receive_data_en_o = i2c_scl_i;  // data stable while scl high
            end
            WRITE_ACK: begin
                sda_low_en_o = 1'b1;
                i2c_sda_en_o = ~full_i;         // release sda as nack when rx fifo full
            end
            STOP: begin
                sda_low_en_o = i2c_sda_i;
                i2c_sda_en_o = 1'b1;
            end
            default: begin
                // READ_ACK and REPEAT_START leave sda released
            end
        endcase
    end

    // -------------------------------------------------------------------
    // fifo strobes
    // -------------------------------------------------------------------
    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            r_fifo_en_o <= 1'b0;
            w_fifo_en_o <= 1'b0;
        end else begin
            // first byte after the address ack is already at the fifo head
            r_fifo_en_o <= (state_q == READ_LATER_ACK) && scl_rise_i;
            w_fifo_en_o <= (state_q == READ_DATA) && (state_d == WRITE_ACK);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/i2c_master_fsm.sv ====
`default_nettype none

module i2c_master_fsm
    import i2c_fsm_pkg::*;
    import i2c_bus_pkg::*;
(
    input  wire logic       enable_i,           // start a transaction
    input  wire logic       reset_ni,
    input  wire logic       repeat_start_i,
    input  wire i2c_dir_e   rw_i,
    input  wire logic       full_i,             // rx fifo full
    input  wire logic       empty_i,            // tx fifo empty
    input  wire logic       i2c_core_clk_i,
    input  wire logic       i2c_sda_i,
    input  wire logic       i2c_scl_i,
    output logic            w_fifo_en_o,
    output logic            r_fifo_en_o,
    output logic            sda_low_en_o,
    output logic            clk_en_o,           // runs the scl generator
    output logic            write_data_en_o,
    output logic            write_addr_en_o,
    output logic            receive_data_en_o,
    output bit_idx_t        count_bit_o,
    output logic            i2c_sda_en_o,
    output logic            i2c_scl_en_o,
    output logic            start_done_o
);

    i2c_state_e state;
    logic       scl_rise;
    logic       scl_fall;
    logic       byte_done;
    logic       read_go;
    logic       write_go;

    // -------------------------------------------------------------------
    // bus sampling
    // -------------------------------------------------------------------
    i2c_bit_timer u_bit_timer (
        .i2c_core_clk_i (i2c_core_clk_i),
        .reset_ni       (reset_ni),
        .i2c_scl_i      (i2c_scl_i),
        .state_i        (state),
        .scl_rise_o     (scl_rise),
        .scl_fall_o     (scl_fall),
        .byte_done_o    (byte_done),
        .count_bit_o    (count_bit_o)
    );

    i2c_ack_monitor u_ack_monitor (
        .i2c_core_clk_i (i2c_core_clk_i),
        .reset_ni       (reset_ni),
        .state_i        (state),
        .scl_rise_i     (scl_rise),     // edge shared so only one scl register exists
        .i2c_sda_i      (i2c_sda_i),
        .full_i         (full_i),
        .empty_i        (empty_i),
        .rw_i           (rw_i),
        .read_go_o      (read_go),
        .write_go_o     (write_go)
    );

    // -------------------------------------------------------------------
    // control
    // -------------------------------------------------------------------
    i2c_sequencer u_sequencer (
        .i2c_core_clk_i    (i2c_core_clk_i),
        .reset_ni          (reset_ni),
        .enable_i          (enable_i),
        .repeat_start_i    (repeat_start_i),
        .full_i            (full_i),
        .empty_i           (empty_i),
        .i2c_sda_i         (i2c_sda_i),
        .i2c_scl_i         (i2c_scl_i),
        .scl_rise_i        (scl_rise),
        .scl_fall_i        (scl_fall),
        .byte_done_i       (byte_done),
        .read_go_i         (read_go),
        .write_go_i        (write_go),
        .state_o           (state),
        .w_fifo_en_o       (w_fifo_en_o),
        .r_fifo_en_o       (r_fifo_en_o),
        .sda_low_en_o      (sda_low_en_o),
        .clk_en_o          (clk_en_o),
        .write_data_en_o   (write_data_en_o),
        .write_addr_en_o   (write_addr_en_o),
        .receive_data_en_o (receive_data_en_o),
        .i2c_sda_en_o      (i2c_sda_en_o),
        .i2c_scl_en_o      (i2c_scl_en_o),
        .start_done_o      (start_done_o)
    );

endmodule

`default_nettype wire

// ==== bench/tb_i2c_master_fsm.sv ====
`default_nettype none

`include "i2c_master_params.svh"

module tb_i2c_master_fsm
    import i2c_fsm_pkg::*;
    import i2c_bus_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS   = 6;
    localparam int WORST_BITS = 48;     // two address bytes, two data bytes, acks, start, stop
    localparam int LIMIT      = 10 + NUM_ROWS * WORST_BITS * 8 + 1000;

    typedef struct {
        i2c_dir_e rw;
        logic     addr_ack;     // slave acks the address
        int       n_bytes;      // bytes before the fifo flag goes active
        logic     rpt;
        int       exp_r;
        int       exp_w;
    } row_t;

    logic i2c_core_clk_i, reset_ni, enable_i, repeat_start_i, full_i, empty_i;
    logic i2c_sda_i, i2c_scl_i;
    i2c_dir_e rw_i;
    logic w_fifo_en_o, r_fifo_en_o, sda_low_en_o, clk_en_o, write_data_en_o;
    logic write_addr_en_o, receive_data_en_o, i2c_sda_en_o, i2c_scl_en_o, start_done_o;
    bit_idx_t count_bit_o;

    row_t       rows [NUM_ROWS];
    row_t       row;
    int         cycles, r_cnt, w_cnt, scl_cnt, gap;
    logic [31:0] rng;
    logic       scl_old, r_prev, w_prev;
    logic       stop_seen, rpt_seen, addr2_seen, last_ack_en;
    i2c_state_e st_prev;
    bit_idx_t   exp_idx;

    i2c_master_fsm u_dut (.*);

    always #20 i2c_core_clk_i = ~i2c_core_clk_i;

    // run limit
    always @(posedge i2c_core_clk_i) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("timeout: transaction did not finish within %0d cycles", LIMIT);
            $display("TB FAILED");
            $fatal(1, "run stopped on timeout");
        end
    end

    // -------------------------------------------------------------------
    // checks
    // -------------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("TB FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            abort_run(what);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
            abort_run(what);
        end
    endtask

    task automatic check_bit(input bit_idx_t got, input bit_idx_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
            abort_run(what);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // -------------------------------------------------------------------
    // one core cycle that checks outputs and then drives bus and fifo flags
    // -------------------------------------------------------------------
    task automatic bus_cycle();
        i2c_state_e st;
        logic       rise;
        logic       fall;
        logic       scl_now;
        @(negedge i2c_core_clk_i);
        st      = u_dut.u_sequencer.state_q;
        scl_now = i2c_scl_i;
        rise    = scl_now & ~scl_old;   // edge seen at the last posedge
        fall    = ~scl_now & scl_old;

        // index steps down once per bit and reloads outside byte phases
        if (st_prev != ADDRESS && st_prev != WRITE_DATA && st_prev != READ_DATA) begin
            exp_idx = `I2C_BIT_MSB;
        end else if (((st_prev == READ_DATA) ? fall : rise) && exp_idx != 0) begin
            exp_idx = exp_idx - 1'b1;
        end
        check_bit(count_bit_o, exp_idx, "bit index");

        if (scl_now) begin
            check_level(write_data_en_o, 1'b0, "write data while scl high");
            check_level(write_addr_en_o, 1'b0, "write address while scl high");
        end
        if (receive_data_en_o) check_level(scl_now, 1'b1, "receive while scl low");

        // master acks at the ack clock unless that byte filled the rx fifo
        if (st == WRITE_ACK && rise) begin
            check_level(i2c_sda_en_o, (w_cnt < row.n_bytes), "master ack drive");
            last_ack_en = i2c_sda_en_o;
        end
        check_level(r_fifo_en_o & r_prev, 1'b0, "r_fifo strobe longer than a cycle");
        check_level(w_fifo_en_o & w_prev, 1'b0, "w_fifo strobe longer than a cycle");
        r_cnt  = r_cnt + int'(r_fifo_en_o);
        w_cnt  = w_cnt + int'(w_fifo_en_o);
        r_prev = r_fifo_en_o;
        w_prev = w_fifo_en_o;

        if (st == STOP && !i2c_sda_i) begin
            check_level(sda_low_en_o, 1'b0, "stop pulls sda while sda low");
        end
        if (st == STOP && sda_low_en_o && i2c_sda_en_o) stop_seen = 1'b1;
        if (row.rpt && !rpt_seen && st == START && w_cnt >= 1 && sda_low_en_o && scl_now) begin
            rpt_seen       = 1'b1;
            repeat_start_i = 1'b0;
        end
        if (rpt_seen && write_addr_en_o) addr2_seen = 1'b1;

        // fifo flags go active after n_bytes strobes
        empty_i = (row.rw == I2C_WRITE) && (r_cnt >= row.n_bytes);
        full_i  = (row.rw == I2C_READ) && (w_cnt >= row.n_bytes);

        // scl model with a half period of 4 core cycles
        if (!clk_en_o) begin
            i2c_scl_i = 1'b1;
            scl_cnt   = 0;
        end else begin
            scl_cnt = scl_cnt + 1;
            if (scl_cnt == 4) begin
                i2c_scl_i = ~i2c_scl_i;
                scl_cnt   = 0;
            end
        end

        // slave model acks in ack slots and mirrors the master pull down in stop
        if (st == READ_ACK) i2c_sda_i = ~row.addr_ack;
        else if (st == READ_LATER_ACK) i2c_sda_i = 1'b0;
        else if (st == STOP) i2c_sda_i = ~sda_low_en_o;
        else i2c_sda_i = 1'b1;

        st_prev = st;
        scl_old = scl_now;
    endtask

    // -------------------------------------------------------------------
    // stimulus
    // -------------------------------------------------------------------
    initial begin
        rows[0] = '{I2C_WRITE, 1'b1, 2, 1'b0, 2, 0};
        rows[1] = '{I2C_WRITE, 1'b0, 2, 1'b0, 0, 0};     // address nack
        rows[2] = '{I2C_READ,  1'b1, 3, 1'b0, 0, 3};
        rows[3] = '{I2C_READ,  1'b1, 2, 1'b1, 0, 2};     // repeated start after byte one
        rows[4] = '{I2C_WRITE, 1'b1, 1, 1'b0, 1, 0};
        rows[5] = '{I2C_READ,  1'b0, 1, 1'b0, 0, 0};
        row = rows[0];
        i2c_core_clk_i = 1'b0;
        reset_ni       = 1'b0;
        enable_i       = 1'b0;
        repeat_start_i = 1'b0;
        full_i         = 1'b0;
        empty_i        = 1'b0;
        rw_i           = I2C_WRITE;
        i2c_sda_i      = 1'b1;
        i2c_scl_i      = 1'b1;
        cycles  = 0;
        rng     = 32'd10;
        scl_cnt = 0;
        scl_old = 1'b1;
        r_prev  = 1'b0;
        w_prev  = 1'b0;
        st_prev = IDLE;
        exp_idx = `I2C_BIT_MSB;
        r_cnt   = 0;
        w_cnt   = 0;
        repeat (10) @(negedge i2c_core_clk_i);
        reset_ni = 1'b1;

        @(negedge i2c_core_clk_i);
        check_level(clk_en_o | i2c_scl_en_o | i2c_sda_en_o | sda_low_en_o, 1'b0, "line enables");
        check_level(write_data_en_o | write_addr_en_o | receive_data_en_o, 1'b0,
                    "datapath enables");
        check_level(r_fifo_en_o | w_fifo_en_o, 1'b0, "fifo strobes");
        check_level(start_done_o, 1'b0, "start_done after reset");

        for (int i = 0; i < NUM_ROWS; i++) begin
            row         = rows[i];
            r_cnt       = 0;
            w_cnt       = 0;
            stop_seen   = 1'b0;
            rpt_seen    = 1'b0;
            addr2_seen  = 1'b0;
            last_ack_en = 1'b1;
            rw_i           = row.rw;
            repeat_start_i = row.rpt;
            empty_i        = 1'b0;
            full_i         = 1'b0;
            enable_i       = 1'b1;
            while (start_done_o !== 1'b1) bus_cycle();
            enable_i = 1'b0;
            while (start_done_o !== 1'b0) bus_cycle();

            check_count(r_cnt, row.exp_r, "r_fifo pulses");
            check_count(w_cnt, row.exp_w, "w_fifo pulses");
            check_level(stop_seen, 1'b1, "stop condition");
            check_level(rpt_seen, row.rpt, "repeated start");
            check_level(addr2_seen, row.rpt, "second address byte");
            if (row.rw == I2C_READ && row.addr_ack) begin
                check_level(last_ack_en, 1'b0, "nack in last ack slot");
            end

            rng = xorshift32(rng);
            gap = 2 + int'(rng % 8);
            repeat (gap) bus_cycle();
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
rtl/i2c_fsm_pkg.sv
rtl/i2c_bus_pkg.sv
rtl/i2c_bit_timer.sv
rtl/i2c_ack_monitor.sv
rtl/i2c_sequencer.sv
rtl/i2c_master_fsm.sv
bench/tb_i2c_master_fsm.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, exit status gives pass or fail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_i2c_master_fsm \
    -o tb_i2c_master_fsm \
    && ./obj_dir/tb_i2c_master_fsm \
    || exit 1
